// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    localparam int data_w     = 8;   // data and address width
    localparam int reg_addr_w = 2;   // four registers
    localparam int imem_depth = 256; // bytes, full pc range
    localparam int dmem_depth = 256; // bytes, full address range

    typedef enum logic [3:0] {
        op_nop = 4'd0,
        op_mov = 4'd1,  // ra <- rb
        op_add = 4'd2,
        op_sub = 4'd3,
        op_and = 4'd4,
        op_or  = 4'd5,
        op_not = 4'd6,  // ra <- ~ra
        op_inc = 4'd7,
        op_in  = 4'd8,  // ra <- in_port
        op_out = 4'd9,  // out_port <- ra
        op_ldm = 4'd10, // two bytes, ra <- next byte
        op_ld  = 4'd11, // ra <- dmem[rb]
        op_st  = 4'd12, // dmem[rb] <- ra
        op_jcc = 4'd13, // pc <- rb if cond holds
        op_hlt = 4'd15  // 14 left reserved
    } opcode_e;

    typedef enum logic [1:0] {
        cond_z      = 2'd0,
        cond_n      = 2'd1,
        cond_c      = 2'd2,
        cond_always = 2'd3
    } cond_e;

    typedef enum logic [2:0] {
        alu_pass_b, alu_add, alu_sub, alu_and, alu_or, alu_not, alu_inc
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu, wb_mem, wb_in_port
    } wb_sel_e;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
    } flags_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    set_zn;    // and, or, not, add, sub, inc
        logic    set_c;     // arithmetic only
        logic    reg_write;
        logic    mem_write;
        logic    io_write;
        wb_sel_e wb_sel;
        logic    is_branch;
        cond_e   cond;      // from the ra field of jcc
        logic    is_halt;
        logic    use_imm;   // ldm takes the second byte as operand b
    } ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [reg_addr_w-1:0] ra;
        logic [reg_addr_w-1:0] rb;
        logic [data_w-1:0]     ra_val;
        logic [data_w-1:0]     rb_val;
        logic [data_w-1:0]     imm;
        logic                  valid; // low for a bubble
    } id_ex_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_write;
        logic                  io_write;
        wb_sel_e               wb_sel;
        logic [reg_addr_w-1:0] rd;
        logic [data_w-1:0]     alu_res; // also the dmem address
        logic [data_w-1:0]     st_data; // ra value for st and out
        logic                  valid;
    } ex_mem_t;

endpackage

// ==== source/pipe_control.sv ====
module pipe_control import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] instr,    // IF/ID instruction byte
    input  ctrl_t             ex_ctrl,
    input  id_ex_t            ex_regs,
    input  ex_mem_t           mem_fwd,
    input  flags_t            flags,
    input  logic [data_w-1:0] target,   // forwarded rb of the jcc
    output ctrl_t             dec_ctrl,
    output logic              fwd_a,
    output logic              fwd_b,
    output logic              redirect,
    output logic              flush,
    output logic              stall,
    output logic              halted
);

    opcode_e opcode;
    logic    cond_ok;
    logic    halt_ex;

    assign opcode = opcode_e'(instr[7:4]);

    always_comb begin
        dec_ctrl = '0; // nop, reserved 14
        case (opcode)
            op_mov: dec_ctrl.reg_write = 1'b1; // pass_b is the zero encoding
            op_add, op_sub, op_inc: begin
                dec_ctrl.alu_op    = (opcode == op_add) ? alu_add :
                                     (opcode == op_sub) ? alu_sub : alu_inc;
                dec_ctrl.set_zn    = 1'b1;
                dec_ctrl.set_c     = 1'b1;
                dec_ctrl.reg_write = 1'b1;
            end
            op_and, op_or, op_not: begin
                dec_ctrl.alu_op    = (opcode == op_and) ? alu_and :
                                     (opcode == op_or)  ? alu_or  : alu_not;
                dec_ctrl.set_zn    = 1'b1; // carry untouched
                dec_ctrl.reg_write = 1'b1;
            end
            op_in: begin
                dec_ctrl.reg_write = 1'b1;
                dec_ctrl.wb_sel    = wb_in_port;
            end
            op_out: dec_ctrl.io_write = 1'b1;
            op_ldm: begin
                dec_ctrl.use_imm   = 1'b1; // second byte through the alu
                dec_ctrl.reg_write = 1'b1;
            end
            op_ld: begin
                dec_ctrl.reg_write = 1'b1; // address is rb via pass_b
                dec_ctrl.wb_sel    = wb_mem;
            end
            op_st: dec_ctrl.mem_write = 1'b1;
            op_jcc: begin
                dec_ctrl.is_branch = 1'b1;
                dec_ctrl.cond      = cond_e'(instr[3:2]);
            end
            op_hlt: dec_ctrl.is_halt = 1'b1;
            default: dec_ctrl = '0;
        endcase
    end

    // EX/MEM result bypass, older value sits in the regfile via write-through
    assign fwd_a = mem_fwd.valid && mem_fwd.reg_write && (mem_fwd.rd == ex_regs.ra);
    assign fwd_b = mem_fwd.valid && mem_fwd.reg_write && (mem_fwd.rd == ex_regs.rb);

    always_comb begin
        case (ex_ctrl.cond)
            cond_z:  cond_ok = flags.z;
            cond_n:  cond_ok = flags.n;
            cond_c:  cond_ok = flags.c;
            default: cond_ok = 1'b1; // always
        endcase
    end

    assign redirect = ex_regs.valid && ex_ctrl.is_branch && cond_ok;
    assign flush    = redirect; // kills IF/ID and ID/EX
    assign halt_ex  = ex_regs.valid && ex_ctrl.is_halt;
    assign stall    = halt_ex || halted;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (halt_ex) begin
            halted <= 1'b1; // sticky until reset
        end
    end

    a_no_redirect_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !(redirect && stall));

    a_halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted);

endmodule

// ==== source/fetch_stage.sv ====
module fetch_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              prog_we,
    input  logic [data_w-1:0] prog_addr,
    input  logic [data_w-1:0] prog_data,
    input  logic              stall,
    input  logic              flush,
    input  logic              redirect,
    input  logic [data_w-1:0] target,
    output logic [data_w-1:0] instr,
    output logic [data_w-1:0] imm
);

    logic [data_w-1:0] imem [imem_depth];
    logic [data_w-1:0] pc;
    logic [data_w-1:0] pc_inc;
    logic [data_w-1:0] byte0;
    logic [data_w-1:0] byte1;
    logic              is_ldm;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    assign pc_inc = pc + 1'b1;
    assign byte0  = imem[pc];     // async read
    assign byte1  = imem[pc_inc]; // immediate if ldm, wraps at 255
    assign is_ldm = (opcode_e'(byte0[7:4]) == op_ldm);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target; // taken jcc
        end else if (!stall) begin
            pc <= is_ldm ? pc + data_w'(2) : pc_inc; // skip the data byte
        end
    end

    // IF/ID
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr <= '0;
        end else if (flush) begin
            instr <= '0; // nop
        end else if (!stall) begin
            instr <= byte0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            imm <= byte1; // only meaningful behind ldm
        end
    end

    a_pc_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(pc));

endmodule

// ==== source/reg_file.sv ====
module reg_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] ra,
    input  logic [reg_addr_w-1:0] rb,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] rd,
    input  logic [data_w-1:0]     wdata,
    output logic [data_w-1:0]     ra_val,
    output logic [data_w-1:0]     rb_val
);

    logic [data_w-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd] <= wdata;
        end
    end

    // write-through, decode sees the value written back this cycle
    assign ra_val = (we && (rd == ra)) ? wdata : regs[ra];
    assign rb_val = (we && (rd == rb)) ? wdata : regs[rb];

endmodule

// ==== source/execute_stage.sv ====
module execute_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic              stall,
    input  id_ex_t            id_in,
    input  logic              fwd_a,
    input  logic              fwd_b,
    input  logic [data_w-1:0] wb_data,  // EX/MEM result
    output ctrl_t             ex_ctrl,
    output id_ex_t            ex_regs,
    output flags_t            flags,
    output logic [data_w-1:0] target,
    output ex_mem_t           ex_out
);

    id_ex_t            id_ex;
    flags_t            flags_q;
    logic [data_w-1:0] a_val;
    logic [data_w-1:0] b_fwd;
    logic [data_w-1:0] b_op;
    logic [data_w-1:0] res;
    logic              carry;

    // ID/EX, bubble on a taken branch or behind hlt
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (flush || stall) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_in;
        end
    end

    assign a_val = fwd_a ? wb_data : id_ex.ra_val;
    assign b_fwd = fwd_b ? wb_data : id_ex.rb_val;
    assign b_op  = id_ex.ctrl.use_imm ? id_ex.imm : b_fwd; // ldm

    always_comb begin
        carry = flags_q.c;
        res   = b_op;
        case (id_ex.ctrl.alu_op)
            alu_pass_b: res = b_op;
            alu_add:    {carry, res} = {1'b0, a_val} + {1'b0, b_op};
            alu_sub:    {carry, res} = {1'b0, a_val} + {1'b0, ~b_op} + 9'd1; // no-borrow carry
            alu_and:    res = a_val & b_op;
            alu_or:     res = a_val | b_op;
            alu_not:    res = ~a_val;
            alu_inc:    {carry, res} = {1'b0, a_val} + 9'd1;
            default:    res = b_op;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags_q <= '0;
        end else if (id_ex.valid) begin
            if (id_ex.ctrl.set_zn) begin
                flags_q.z <= (res == '0);
                flags_q.n <= res[data_w-1];
            end
            if (id_ex.ctrl.set_c) begin
                flags_q.c <= carry;
            end
        end
    end

    assign ex_ctrl = id_ex.ctrl;
    assign ex_regs = id_ex;
    assign flags   = flags_q;
    assign target  = b_fwd; // jump address, never the immediate

    assign ex_out = '{reg_write: id_ex.ctrl.reg_write,
                      mem_write: id_ex.ctrl.mem_write,
                      io_write:  id_ex.ctrl.io_write,
                      wb_sel:    id_ex.ctrl.wb_sel,
                      rd:        id_ex.ra,   // every write targets ra
                      alu_res:   res,
                      st_data:   a_val,      // st and out send ra
                      valid:     id_ex.valid};

endmodule

// ==== source/mem_wb_stage.sv ====
module mem_wb_stage import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ex_mem_t               ex_in,
    input  logic [data_w-1:0]     in_port,
    output ex_mem_t               mem_fwd,
    output logic                  wb_we,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [data_w-1:0]     wb_data,
    output logic [data_w-1:0]     out_port,
    output logic                  out_valid
);

    ex_mem_t           ex_mem;
    logic [data_w-1:0] dmem [dmem_depth];
    logic [data_w-1:0] rd_data;
    logic              io_fire;

    // EX/MEM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_in;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_mem.valid && ex_mem.mem_write) begin
            dmem[ex_mem.alu_res] <= ex_mem.st_data;
        end
    end

    assign rd_data = dmem[ex_mem.alu_res]; // async, no load-use stall

    always_comb begin
        case (ex_mem.wb_sel)
            wb_mem:     wb_data = rd_data;
            wb_in_port: wb_data = in_port; // sampled in this stage
            default:    wb_data = ex_mem.alu_res;
        endcase
    end

    assign wb_we   = ex_mem.valid && ex_mem.reg_write; // regfile writes at the edge
    assign wb_rd   = ex_mem.rd;
    assign mem_fwd = ex_mem;
    assign io_fire = ex_mem.valid && ex_mem.io_write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_port  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= io_fire; // single-cycle strobe
            if (io_fire) begin
                out_port <= ex_mem.st_data;
            end
        end
    end

    a_out_from_io: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(ex_mem.valid && ex_mem.io_write));

endmodule

// ==== source/cpu_top.sv ====
module cpu_top import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] in_port,
    input  logic              prog_we,   // imem load, core held in reset
    input  logic [data_w-1:0] prog_addr,
    input  logic [data_w-1:0] prog_data,
    output logic [data_w-1:0] out_port,
    output logic              out_valid,
    output logic              halted
);

    logic [data_w-1:0]     instr;      // IF/ID
    logic [data_w-1:0]     imm;
    ctrl_t                 dec_ctrl;
    logic [data_w-1:0]     ra_val;
    logic [data_w-1:0]     rb_val;
    id_ex_t                id_in;
    ctrl_t                 ex_ctrl;
    id_ex_t                ex_regs;
    flags_t                flags;
    logic [data_w-1:0]     target;
    ex_mem_t               ex_out;
    ex_mem_t               mem_fwd;
    logic                  wb_we;
    logic [reg_addr_w-1:0] wb_rd;
    logic [data_w-1:0]     wb_data;
    logic                  fwd_a;
    logic                  fwd_b;
    logic                  redirect;
    logic                  flush;
    logic                  stall;

    // decode bundle into ID/EX
    assign id_in = '{ctrl:   dec_ctrl,
                     ra:     instr[3:2],
                     rb:     instr[1:0],
                     ra_val: ra_val,
                     rb_val: rb_val,
                     imm:    imm,
                     valid:  1'b1};

    pipe_control u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .ex_ctrl  (ex_ctrl),
        .ex_regs  (ex_regs),
        .mem_fwd  (mem_fwd),
        .flags    (flags),
        .target   (target),
        .dec_ctrl (dec_ctrl),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .redirect (redirect),
        .flush    (flush),
        .stall    (stall),
        .halted   (halted)
    );

    fetch_stage u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .stall     (stall),
        .flush     (flush),
        .redirect  (redirect),
        .target    (target),
        .instr     (instr),
        .imm       (imm)
    );

    reg_file u_rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .ra     (instr[3:2]),
        .rb     (instr[1:0]),
        .we     (wb_we),
        .rd     (wb_rd),
        .wdata  (wb_data),
        .ra_val (ra_val),
        .rb_val (rb_val)
    );

    execute_stage u_ex (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .stall   (stall),
        .id_in   (id_in),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b),
        .wb_data (wb_data),
        .ex_ctrl (ex_ctrl),
        .ex_regs (ex_regs),
        .flags   (flags),
        .target  (target),
        .ex_out  (ex_out)
    );

    mem_wb_stage u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_in     (ex_out),
        .in_port   (in_port),
        .mem_fwd   (mem_fwd),
        .wb_we     (wb_we),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .out_port  (out_port),
        .out_valid (out_valid)
    );

endmodule

// ==== test/cpu_ref.svh ====
`ifndef CPU_REF_SVH
`define CPU_REF_SVH

typedef logic [7:0] byte_q_t [$];

localparam int          max_ref_steps = 1000;         // guards a runaway branch loop
localparam logic [31:0] lfsr_taps     = 32'h80200003; // x^32 + x^22 + x^2 + x + 1

// galois form, shifts right, feedback from bit 0
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
endfunction

// runs the image one instruction at a time until hlt, returns the out values in order
function automatic byte_q_t ref_run(input logic [7:0] prog [imem_depth],
                                    input logic [7:0] in_val);
    byte_q_t    outs;
    logic [7:0] r [4];
    logic [7:0] dm [dmem_depth];
    logic [7:0] pc;
    logic [7:0] ins;
    logic [8:0] sum;
    logic [1:0] a;
    logic [1:0] b;
    logic       z;
    logic       n;
    logic       c;
    logic       hit;
    pc = '0;
    z  = 1'b0;
    n  = 1'b0;
    c  = 1'b0;
    for (int i = 0; i < 4; i++) r[i] = '0;
    for (int i = 0; i < dmem_depth; i++) dm[i] = '0;
    for (int step = 0; step < max_ref_steps; step++) begin
        ins = prog[pc];
        a   = ins[3:2];
        b   = ins[1:0];
        pc  = pc + 8'd1;
        sum = '0;
        case (ins[7:4])
            op_mov: r[a] = r[b];
            op_add: sum = {1'b0, r[a]} + {1'b0, r[b]};
            op_sub: sum = {1'b0, r[a]} + {1'b0, ~r[b]} + 9'd1; // carry means no borrow
            op_inc: sum = {1'b0, r[a]} + 9'd1;
            op_and: r[a] = r[a] & r[b];
            op_or:  r[a] = r[a] | r[b];
            op_not: r[a] = ~r[a];
            op_in:  r[a] = in_val;
            op_out: outs.push_back(r[a]);
            op_ldm: begin
                r[a] = prog[pc]; // second byte
                pc   = pc + 8'd1;
            end
            op_ld:  r[a] = dm[r[b]];
            op_st:  dm[r[b]] = r[a];
            op_jcc: begin
                case (a) // ra field is the condition
                    2'd0:    hit = z;
                    2'd1:    hit = n;
                    2'd2:    hit = c;
                    default: hit = 1'b1;
                endcase
                if (hit) pc = r[b];
            end
            op_hlt: return outs;
            default: ; // nop and reserved 14
        endcase
        if (ins[7:4] inside {op_add, op_sub, op_inc}) begin
            r[a] = sum[7:0];
            c    = sum[8];
        end
        if (ins[7:4] inside {op_add, op_sub, op_inc, op_and, op_or, op_not}) begin
            z = (r[a] == 8'd0);
            n = r[a][7];
        end
    end
    return outs; // no hlt reached, the watchdog catches the DUT side
endfunction

`endif

// ==== test/cpu_tb.sv ====
module cpu_tb import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          clk_period         = 20;
    localparam int          reset_cycles       = 10;
    localparam int          post_halt_cycles   = 20; // idle time watched after hlt
    localparam int          num_random         = 20;
    localparam int          num_programs       = 4 + num_random;
    localparam int          cycles_per_program = 600;
    localparam logic [31:0] lfsr_seed          = 32'h285c4709;

    logic              clk = 1'b0;
    logic              rst_n;
    logic [data_w-1:0] in_port;
    logic              prog_we;
    logic [data_w-1:0] prog_addr;
    logic [data_w-1:0] prog_data;
    logic [data_w-1:0] out_port;
    logic              out_valid;
    logic              halted;

    `include "cpu_ref.svh"

    logic [data_w-1:0] img [imem_depth]; // program image, loaded whole
    int                img_len;
    byte_q_t           exp_q;
    logic [31:0]       lfsr_state;
    bit                first_cycle;
    bit                out_seen;
    bit                halt_seen;
    int                mismatch_errs;
    int                other_errs;
    int                programs_run;

    cpu_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_port   (in_port),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_port  (out_port),
        .out_valid (out_valid),
        .halted    (halted)
    );

    always #(clk_period / 2) clk = ~clk;

    // one lfsr step per bit
    function automatic logic [7:0] rand_bits(input int nbits);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v          = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // unused bytes hold hlt, low nibble from the whole address
    task automatic clear_image();
        for (int i = 0; i < imem_depth; i++) begin
            img[i] = {4'hF, 4'(i >> 4) ^ 4'(i)};
        end
        img_len = 0;
    endtask

    task automatic emit_byte(input logic [7:0] val);
        img[img_len] = val;
        img_len++;
    endtask

    task automatic emit_op(input opcode_e op, input logic [1:0] a, input logic [1:0] b);
        emit_byte({op, a, b});
    endtask

    task automatic emit_ldm(input logic [1:0] a, input logic [7:0] val);
        emit_op(op_ldm, a, 2'd0);
        emit_byte(val);
    endtask

    // target lands just past the two outs, which sit in the flushed slots
    task automatic emit_branch(input cond_e cond);
        emit_ldm(2'd3, 8'(img_len + 5));
        emit_op(op_jcc, cond, 2'd3);
        emit_op(op_out, 2'd0, 2'd0);
        emit_op(op_out, 2'd1, 2'd0);
    endtask

    task automatic build_alu_program();
        clear_image();
        emit_ldm(2'd0, 8'h5A);
        emit_ldm(2'd1, 8'h3C);
        emit_op(op_add, 2'd0, 2'd1); // every op uses the previous result
        emit_op(op_sub, 2'd1, 2'd0);
        emit_op(op_and, 2'd0, 2'd1);
        emit_op(op_or, 2'd1, 2'd0);
        emit_op(op_not, 2'd0, 2'd0);
        emit_op(op_inc, 2'd0, 2'd0);
        emit_op(op_mov, 2'd2, 2'd0);
        emit_op(op_add, 2'd2, 2'd2);
        emit_op(op_out, 2'd2, 2'd0);
        emit_op(op_out, 2'd0, 2'd0);
        emit_op(op_out, 2'd1, 2'd0);
        emit_op(op_inc, 2'd3, 2'd0);
        emit_op(op_mov, 2'd1, 2'd3);
        emit_op(op_sub, 2'd1, 2'd2);
        emit_op(op_out, 2'd1, 2'd0);
        emit_op(op_out, 2'd3, 2'd0);
        emit_op(op_nop, 2'd0, 2'd0);
        emit_op(op_hlt, 2'd0, 2'd0);
    endtask

    task automatic build_mem_program();
        clear_image();
        emit_op(op_in, 2'd0, 2'd0);
        emit_ldm(2'd1, 8'h40);
        emit_op(op_st, 2'd0, 2'd1);
        emit_ldm(2'd2, 8'h41);
        emit_ldm(2'd3, 8'h99);
        emit_op(op_st, 2'd3, 2'd2);
        emit_op(op_ld, 2'd3, 2'd1);
        emit_op(op_out, 2'd3, 2'd0); // load result forwarded
        emit_op(op_ld, 2'd0, 2'd2);
        emit_op(op_out, 2'd0, 2'd0);
        emit_op(op_add, 2'd0, 2'd3);
        emit_op(op_st, 2'd0, 2'd0);
        emit_op(op_ld, 2'd2, 2'd1); // same address as the store before
        emit_op(op_out, 2'd2, 2'd0);
        emit_op(op_in, 2'd2, 2'd0);
        emit_op(op_out, 2'd2, 2'd0);
        emit_op(op_hlt, 2'd0, 2'd0);
    endtask

    task automatic build_branch_program();
        clear_image();
        emit_ldm(2'd0, 8'h11);
        emit_ldm(2'd1, 8'h22);
        emit_ldm(2'd2, 8'h00);
        emit_op(op_sub, 2'd2, 2'd2); // z=1 n=0 c=1
        emit_branch(cond_z);         // taken
        emit_branch(cond_n);         // not taken
        emit_branch(cond_c);         // taken
        emit_ldm(2'd2, 8'h7F);
        emit_op(op_inc, 2'd2, 2'd0); // z=0 n=1 c=0
        emit_branch(cond_z);         // not taken
        emit_branch(cond_n);         // taken
        emit_branch(cond_c);         // not taken
        emit_branch(cond_always);
        emit_ldm(2'd3, 8'(img_len + 6)); // past sub, jcc and the two outs
        emit_op(op_sub, 2'd2, 2'd2);     // flags straight into the jcc
        emit_op(op_jcc, cond_z, 2'd3);
        emit_op(op_out, 2'd0, 2'd0);
        emit_op(op_out, 2'd1, 2'd0);
        emit_op(op_out, 2'd2, 2'd0);
        emit_op(op_hlt, 2'd0, 2'd0);
    endtask

    task automatic build_halt_program();
        clear_image();
        emit_ldm(2'd0, 8'h5E);
        emit_op(op_out, 2'd0, 2'd0);
        emit_op(op_inc, 2'd0, 2'd0);
        emit_op(op_out, 2'd0, 2'd0);
        emit_op(op_not, 2'd0, 2'd0);
        emit_op(op_out, 2'd0, 2'd0); // right before hlt, still comes out
        emit_op(op_hlt, 2'd0, 2'd0);
        emit_op(op_out, 2'd0, 2'd0); // younger than hlt, never seen
        emit_op(op_inc, 2'd0, 2'd0);
        emit_op(op_out, 2'd0, 2'd0);
    endtask

    // straight line, ld only behind a st through the same rb
    task automatic build_random_program();
        int         n_ins;
        logic [3:0] kind;
        logic [1:0] a;
        logic [1:0] b;
        clear_image();
        n_ins = 16 + int'(rand_bits(4));
        for (int i = 0; i < n_ins; i++) begin
            kind = 4'(rand_bits(4));
            a    = 2'(rand_bits(2));
            b    = 2'(rand_bits(2));
            case (kind)
                4'd8:  emit_op(op_in, a, b);
                4'd10: emit_ldm(a, rand_bits(8));
                4'd11: begin
                    emit_op(op_st, a, b);
                    emit_op(op_ld, 2'(rand_bits(2)), b);
                end
                4'd12: emit_op(op_st, a, b);
                4'd13: emit_byte({4'd14, a, b}); // reserved code
                4'd9, 4'd14, 4'd15: emit_op(op_out, a, b);
                default: emit_op(opcode_e'(kind), a, b); // nop .. inc
            endcase
        end
        emit_op(op_hlt, 2'd0, 2'd0);
    endtask

    task automatic run_program(input logic [7:0] in_val);
        @(negedge clk);
        rst_n       = 1'b0;
        in_port     = in_val;
        first_cycle = 1'b1;
        out_seen    = 1'b0;
        halt_seen   = 1'b0;
        exp_q       = ref_run(img, in_val);
        for (int i = 0; i < imem_depth; i++) begin
            prog_we   = 1'b1;
            prog_addr = 8'(i);
            prog_data = img[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        wait (halt_seen);
        repeat (post_halt_cycles) @(negedge clk); // halted must hold, no more outs
        programs_run++;
    endtask

    // samples before the edge, DUT outputs settle through nonblocking updates
    always @(posedge clk) begin : compare_outputs
        logic [7:0] want;
        if (rst_n) begin
            if (first_cycle) begin
                assert (!out_valid && !halted && out_port == 8'h00) else begin
                    other_errs++;
                    $display("outputs not cleared by reset: out_valid=%0b halted=%0b",
                             out_valid, halted);
                end
                first_cycle = 1'b0;
            end
            if (!out_seen && !out_valid) begin
                assert (out_port == 8'h00) else begin
                    mismatch_errs++;
                    $display("MISMATCH out_port expected %h actual %h", 8'h00, out_port);
                end
            end
            if (out_valid) begin
                out_seen = 1'b1;
                assert (!halt_seen) else begin
                    other_errs++;
                    $display("out_valid rose after the core had halted");
                end
                assert (exp_q.size() > 0) else begin
                    other_errs++;
                    $display("out_valid with no expected output left, out_port %h", out_port);
                end
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                    assert (out_port == want) else begin
                        mismatch_errs++;
                        $display("MISMATCH out_port expected %h actual %h", want, out_port);
                    end
                end
            end
            if (halt_seen) begin
                assert (halted) else begin
                    other_errs++;
                    $display("halted dropped without a reset");
                end
            end else if (halted) begin
                assert (exp_q.size() == 0) else begin
                    other_errs++;
                    $display("core halted with %0d expected outputs missing", exp_q.size());
                end
                halt_seen = 1'b1;
            end
        end
    end

    initial begin : watchdog
        #(num_programs * cycles_per_program * clk_period);
        $display("timeout after %0d cycles, %0d programs finished",
                 num_programs * cycles_per_program, programs_run);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        rst_n         = 1'b0;
        in_port       = '0;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        lfsr_state    = lfsr_seed;
        mismatch_errs = 0;
        other_errs    = 0;
        programs_run  = 0;
        build_alu_program();
        run_program(8'h00);
        build_mem_program();
        run_program(8'hA7); // in_port constant for the whole run
        build_branch_program();
        run_program(8'h00);
        build_halt_program();
        run_program(8'h00);
        repeat (num_random) begin
            build_random_program();
            run_program(rand_bits(8));
        end
        $display("%0d programs run, %0d mismatches, %0d other errors",
                 programs_run, mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+test
source/cpu_pkg.sv
source/pipe_control.sv
source/fetch_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/cpu_top.sv
test/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: pipe_cpu8

sources:
  - files:
      - source/cpu_pkg.sv
      - source/pipe_control.sv
      - source/fetch_stage.sv
      - source/reg_file.sv
      - source/execute_stage.sv
      - source/mem_wb_stage.sv
      - source/cpu_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/cpu_tb.sv
